// File: src.f
field_pkg.sv
piece_pkg.sv
piece_regs.sv
piece_mover.sv
piece_shaper.sv
collision_probe.sv
playfield.sv
tetris_core.sv
tb_clock_gen.sv
tetris_properties.sv
tb_tetris.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_tetris -f src.f \
    -o sim_tetris > sim.log 2>&1 \
    && ./obj_dir/sim_tetris >> sim.log 2>&1 \
    || echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

// File: tb_tetris.sv
`timescale 1ns/1ps

module tb_tetris
    import field_pkg::*, piece_pkg::*;
();

    localparam int SCRIPT_CYCLES = 1500;                   // upper bound of the scripted run
    localparam int CYCLE_LIMIT = 2 * SCRIPT_CYCLES + 100;

    logic reset, clk, wr_en, move_left, move_right, move_down, rotate;
    logic [1:0] wr_addr;
    reg_data_t wr_data;
    logic [4:0] row_sel;
    coord_t anchor_col, anchor_row;
    coord_t cell_col0, cell_col1, cell_col2, cell_col3;
    coord_t cell_row0, cell_row1, cell_row2, cell_row3;
    shape_t shape;
    rot_t rot;
    logic at_left, at_right, at_bottom, locked;
    row_bits_t row_bits;
    row_bits_t exp_row [FIELD_ROWS];  // expected occupancy with one bit per column
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic done = 1'b0;
    logic [31:0] rand_state = 32'd31;

    tb_clock_gen i_clk (.reset(reset), .clk(clk));

    tetris_core i_dut (.*);

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic host_write(logic [1:0] addr, reg_data_t data);
        @(posedge reset);
        wr_en <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge reset);
        wr_en <= 1'b0;
    endtask

    task automatic pulse(int kind);  // 0 left, 1 right, 2 down, 3 rotate
        @(posedge reset);
        move_left <= (kind == 0);
        move_right <= (kind == 1);
        move_down <= (kind == 2);
        rotate <= (kind == 3);
        @(posedge reset);
        {move_left, move_right, move_down, rotate} <= 4'b0;
    endtask

    task automatic drop_piece();
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 25) begin
            pulse(2);
            @(negedge reset);
            seen = locked;
            n++;
        end
        checks++;
        if (!seen) begin
            errors++;
            $display("piece did not lock within 25 down strobes");
        end
    endtask

    task automatic clear_field_now();
        host_write(REG_CLEAR, 8'h00);
        repeat (2) @(posedge reset);
        for (int r = 0; r < FIELD_ROWS; r++) exp_row[r] = '0;
    endtask

    // O or I at rotation 0, dropped from the spawn row onto the expected stack
    function automatic void land(logic is_o, int c);
        row_bits_t m0;
        row_bits_t m1;
        int h;
        int r;
        m0 = is_o ? row_bits_t'(3 << c) : row_bits_t'(15 << (c - 1));
        m1 = is_o ? m0 : '0;
        h = is_o ? 1 : 0;
        r = 1;
        while (r + 1 + h < FIELD_ROWS && (exp_row[r + 1] & m0) == 0 &&
               (exp_row[r + 1 + h] & m1) == 0) r++;
        exp_row[r] |= m0;
        exp_row[r + h] |= m1;
    endfunction

    task automatic check_rows();
        for (int r = 0; r < FIELD_ROWS; r++) begin
            @(posedge reset);
            row_sel <= 5'(r);
            @(negedge reset);
            checks++;
            if (row_bits !== exp_row[r]) begin
                errors++;
                $display("FAILED row_bits row %0d: got %h expected %h", r, row_bits, exp_row[r]);
            end
        end
    endtask

    always @(posedge reset) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            done = 1'b1;
            $display("timeout after %0d cycles", cycles);
            $display("checks: %0d errors: %0d", checks, errors);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        {wr_en, move_left, move_right, move_down, rotate} = 5'b0;
        wr_addr = '0;
        wr_data = '0;
        row_sel = '0;
        for (int r = 0; r < FIELD_ROWS; r++) exp_row[r] = '0;
        @(negedge clk);
        repeat (2) @(posedge reset);
        host_write(REG_PAUSE, 8'h01);  // moves are dropped while paused
        for (int k = 0; k < 4; k++) pulse(k);
        host_write(REG_PAUSE, 8'h00);
        host_write(REG_NEXT_SHAPE, 8'h07);  // out of range and ignored
        host_write(REG_SPAWN_COL, 8'h0c);
        for (int s = 0; s < 7; s++) begin
            host_write(REG_NEXT_SHAPE, reg_data_t'(s));
            drop_piece();
            clear_field_now();
            repeat (2) pulse(2);  // room above the piece for every turn of the bar
            repeat (4) pulse(3);
            repeat (12) pulse(0);  // against the left wall, then rotate there
            repeat (4) pulse(3);
            repeat (12) pulse(1);
            repeat (4) pulse(3);
            repeat (20) begin
                rand_state = lcg_next(rand_state);
                pulse(int'(rand_state[17:16] == 2'd2 ? 2'd3 : rand_state[17:16]));
            end
        end
        host_write(REG_SPAWN_COL, 8'h00);
        host_write(REG_NEXT_SHAPE, reg_data_t'(SHAPE_O));
        drop_piece();
        clear_field_now();
        host_write(REG_NEXT_SHAPE, reg_data_t'(SHAPE_I));
        host_write(REG_SPAWN_COL, 8'h01);
        drop_piece();
        land(1'b1, 0);
        check_rows();
        drop_piece();  // I lands on top of the O
        land(1'b0, 1);
        check_rows();
        clear_field_now();
        check_rows();
        done = 1'b1;
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    final begin
        if (!done) begin
            $display("run stopped before the end");
            $display("Errors found");
        end
    end

endmodule

// File: tetris_properties.sv
`timescale 1ns/1ps

module tetris_properties
    import field_pkg::*, piece_pkg::*;
(
    input logic      reset,
    input logic      clk,
    input logic      wr_en,
    input logic [1:0] wr_addr,
    input reg_data_t wr_data,
    input logic      move_left,
    input logic      move_right,
    input logic      move_down,
    input logic      rotate,
    input coord_t    anchor_col,
    input coord_t    anchor_row,
    input shape_t    shape,
    input rot_t      rot,
    input coord_t    cell_col0, cell_col1, cell_col2, cell_col3,
    input coord_t    cell_row0, cell_row1, cell_row2, cell_row3,
    input logic      at_left,
    input logic      at_right,
    input logic      at_bottom,
    input logic      locked,
    input row_bits_t row_bits
);

    logic   pause_m;   // host settings as the register map defines them
    coord_t spawn_m;
    shape_t next_m;
    logic   clr_pend;  // clear write waiting for its grid edge
    logic   empty_m;   // no cell locked since the last clear
    logic   left_ok;
    logic   down_sel;
    logic   touch_l;   // a cell sits in the leftmost column
    logic   touch_r;
    logic   touch_b;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pause_m  <= 1'b0;
            spawn_m  <= 6'sd4;
            next_m   <= SHAPE_O;
            clr_pend <= 1'b0;
            empty_m  <= 1'b1;
        end else begin
            clr_pend <= wr_en && (wr_addr == REG_CLEAR);
            if (clr_pend) begin
                empty_m <= 1'b1;  // grid empties two edges after the write
            end else if (down_sel && at_bottom) begin
                empty_m <= 1'b0;
            end
            if (wr_en) begin
                if (wr_addr == REG_PAUSE) pause_m <= wr_data[0];
                if (wr_addr == REG_SPAWN_COL && wr_data < 8'd10) spawn_m <= coord_t'(wr_data[5:0]);
                if (wr_addr == REG_NEXT_SHAPE && wr_data < 8'd7) next_m <= shape_t'(wr_data[2:0]);
            end
        end
    end

    assign left_ok  = move_left && !at_left;
    assign down_sel = !pause_m && !left_ok && move_down;

    // cells packed as four columns then four rows, taken from the offset table
    function automatic logic [47:0] expect_cells(coord_t ac, coord_t ar, shape_t s, rot_t r);
        int dc[4];
        int dr[4];
        int t;
        logic [47:0] v;
        dc = '{0, 1, 0, 1};
        dr = '{0, 0, 1, 1};
        case (s)
            SHAPE_I: begin
                dc = '{-1, 0, 1, 2};
                dr = '{0, 0, 0, 0};
            end
            SHAPE_S: begin
                dc = '{0, 1, -1, 0};
                dr = '{0, 0, 1, 1};
            end
            SHAPE_Z: begin
                dc = '{-1, 0, 0, 1};
                dr = '{0, 0, 1, 1};
            end
            SHAPE_L: begin
                dc = '{-1, 0, 1, 1};
                dr = '{0, 0, 0, 1};
            end
            SHAPE_J: begin
                dc = '{-1, 0, 1, -1};
                dr = '{0, 0, 0, 1};
            end
            SHAPE_T: begin
                dc = '{-1, 0, 1, 0};
                dr = '{0, 0, 0, 1};
            end
            default: begin end
        endcase
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < ((s == SHAPE_O) ? 0 : int'(r)); k++) begin
                t = dc[i];
                dc[i] = -dr[i];  // one clockwise quarter turn
                dr[i] = t;
            end
            v[47 - 6 * i -: 6] = coord_t'(int'(ac) + dc[i]);
            v[23 - 6 * i -: 6] = coord_t'(int'(ar) + dr[i]);
        end
        return v;
    endfunction

    function automatic logic off_field(logic [47:0] v);
        logic res;
        res = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if ($signed(v[47 - 6 * i -: 6]) < 0 || $signed(v[47 - 6 * i -: 6]) > 9) res = 1'b1;
            if ($signed(v[23 - 6 * i -: 6]) < 0 || $signed(v[23 - 6 * i -: 6]) > 19) res = 1'b1;
        end
        return res;
    endfunction

    // true when one of four packed coordinates equals the given value
    function automatic logic touches(logic [23:0] v, int w);
        logic res;
        res = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if ($signed(v[23 - 6 * i -: 6]) == w) res = 1'b1;
        end
        return res;
    endfunction

    assign touch_l = touches({cell_col0, cell_col1, cell_col2, cell_col3}, 0);
    assign touch_r = touches({cell_col0, cell_col1, cell_col2, cell_col3}, 9);
    assign touch_b = touches({cell_row0, cell_row1, cell_row2, cell_row3}, 19);

    a_reset: assert property (@(posedge reset) $fell(clk) |-> anchor_col == 6'sd4 &&
        anchor_row == SPAWN_ROW && rot == 2'd0 && shape == SHAPE_O && !locked && row_bits == '0)
        else $error("FAILED reset state: col %h row %h shape %h", anchor_col, anchor_row, shape);

    a_left: assert property (@(posedge reset) disable iff (clk)
        !pause_m && left_ok |=> anchor_col == $past(anchor_col) - 6'sd1)
        else $error("FAILED anchor_col: got %h expected %h", anchor_col, $past(anchor_col) - 6'sd1);

    a_down: assert property (@(posedge reset) disable iff (clk)
        down_sel && !at_bottom |=> anchor_row == $past(anchor_row) + 6'sd1)
        else $error("FAILED anchor_row: got %h expected %h", anchor_row, $past(anchor_row) + 6'sd1);

    a_right: assert property (@(posedge reset) disable iff (clk)
        !pause_m && !left_ok && !move_down && move_right && !at_right
        |=> anchor_col == $past(anchor_col) + 6'sd1)
        else $error("FAILED anchor_col: got %h expected %h", anchor_col, $past(anchor_col) + 6'sd1);

    a_wall: assert property (@(posedge reset) disable iff (clk)
        ((move_left && at_left) || (move_right && at_right)) && !move_down && !rotate &&
        !(move_left && move_right) |=> $stable(anchor_col) && $stable(anchor_row))
        else $error("FAILED anchor_col: got %h expected %h", anchor_col, $past(anchor_col));

    // with an empty field only the walls and the floor can raise the flags
    a_flags: assert property (@(posedge reset) disable iff (clk)
        (at_left ? (touch_l || !empty_m) : !touch_l) &&
        (at_right ? (touch_r || !empty_m) : !touch_r) &&
        (at_bottom ? (touch_b || !empty_m) : !touch_b))
        else $error("FAILED at_left at_right at_bottom: got %h %h %h expected %h %h %h",
            at_left, at_right, at_bottom, touch_l, touch_r, touch_b);

    a_pause: assert property (@(posedge reset) disable iff (clk) pause_m |=> $stable(anchor_col)
        && $stable(anchor_row) && $stable(rot) && $stable(shape))
        else $error("FAILED anchor_col: got %h expected %h while paused", anchor_col,
            $past(anchor_col));

    a_geom: assert property (@(posedge reset) disable iff (clk)
        {cell_col0, cell_col1, cell_col2, cell_col3, cell_row0, cell_row1, cell_row2, cell_row3}
        == expect_cells(anchor_col, anchor_row, shape, rot))
        else $error("FAILED cells: got %h expected %h", {cell_col0, cell_col1, cell_col2,
            cell_col3, cell_row0, cell_row1, cell_row2, cell_row3},
            expect_cells(anchor_col, anchor_row, shape, rot));

    a_rot_wall: assert property (@(posedge reset) disable iff (clk)
        !pause_m && rotate && !move_left && !move_down && !move_right &&
        off_field(expect_cells(anchor_col, anchor_row, shape, rot + 2'd1)) |=> $stable(rot))
        else $error("FAILED rot: got %h expected %h", rot, $past(rot));

    a_rot_turn: assert property (@(posedge reset) disable iff (clk)
        empty_m && !pause_m && rotate && !move_left && !move_down && !move_right &&
        !off_field(expect_cells(anchor_col, anchor_row, shape, rot + 2'd1))
        |=> rot == $past(rot) + 2'd1)
        else $error("FAILED rot: got %h expected %h", rot, $past(rot) + 2'd1);

    a_rot_step: assert property (@(posedge reset) disable iff (clk)
        !(down_sel && at_bottom) |=> rot == $past(rot) || rot == $past(rot) + 2'd1)
        else $error("FAILED rot: got %h from %h", rot, $past(rot));

    a_lock: assert property (@(posedge reset) disable iff (clk) down_sel && at_bottom
        |=> locked && anchor_col == $past(spawn_m) && anchor_row == SPAWN_ROW &&
        shape == $past(next_m) && rot == 2'd0)
        else $error("FAILED spawn: col %h expected %h shape %h expected %h", anchor_col,
            $past(spawn_m), shape, $past(next_m));

    a_locked_cause: assert property (@(posedge reset) disable iff (clk)
        !(down_sel && at_bottom) |=> !locked)
        else $error("FAILED locked: got %h expected %h", locked, 1'b0);

endmodule

bind tetris_core tetris_properties i_props (.*);

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic reset,
    output logic clk
);

    initial begin
        reset = 1'b0;
        forever #20 reset = ~reset;  // 40 ns period
    end

    initial begin
        clk = 1'b1;
        repeat (2) @(posedge reset);
        @(negedge reset);
        clk = 1'b0;  // released away from the active edge
    end

endmodule

// File: tetris_core.sv
`timescale 1ns/1ps

module tetris_core
    import field_pkg::*, piece_pkg::*;
(
    input  logic       reset,
    input  logic       clk,
    input  logic       wr_en,
    input  logic [1:0] wr_addr,
    input  reg_data_t  wr_data,
    input  logic       move_left,
    input  logic       move_right,
    input  logic       move_down,
    input  logic       rotate,
    input  logic [4:0] row_sel,
    output coord_t     anchor_col,
    output coord_t     anchor_row,
    output shape_t     shape,
    output rot_t       rot,
    output coord_t     cell_col0,
    output coord_t     cell_col1,
    output coord_t     cell_col2,
    output coord_t     cell_col3,
    output coord_t     cell_row0,
    output coord_t     cell_row1,
    output coord_t     cell_row2,
    output coord_t     cell_row3,
    output logic       at_left,
    output logic       at_right,
    output logic       at_bottom,
    output logic       locked,
    output row_bits_t  row_bits
);

    logic   pause;
    coord_t spawn_col;
    shape_t next_shape;
    logic   clear_field;
    logic   rot_blocked;
    logic   lock;
    rot_t   rot_next;
    grid_t  grid;
    coord_t rot_col0, rot_col1, rot_col2, rot_col3;
    coord_t rot_row0, rot_row1, rot_row2, rot_row3;

    assign rot_next = rot + rot_t'(1);  // candidate one turn ahead

    piece_regs i_regs (
        .reset(reset), .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .pause(pause), .spawn_col(spawn_col), .next_shape(next_shape),
        .clear_field(clear_field)
    );

    piece_mover i_mover (
        .reset(reset), .clk(clk), .move_left(move_left), .move_right(move_right),
        .move_down(move_down), .rotate(rotate), .pause(pause), .spawn_col(spawn_col),
        .next_shape(next_shape), .at_left(at_left), .at_right(at_right),
        .at_bottom(at_bottom), .rot_blocked(rot_blocked), .anchor_col(anchor_col),
        .anchor_row(anchor_row), .shape(shape), .rot(rot), .lock(lock), .locked(locked)
    );

    piece_shaper i_shaper_cur (
        .anchor_col(anchor_col), .anchor_row(anchor_row), .shape(shape), .rot(rot),
        .cell_col0(cell_col0), .cell_col1(cell_col1),
        .cell_col2(cell_col2), .cell_col3(cell_col3),
        .cell_row0(cell_row0), .cell_row1(cell_row1),
        .cell_row2(cell_row2), .cell_row3(cell_row3)
    );

    piece_shaper i_shaper_rot (
        .anchor_col(anchor_col), .anchor_row(anchor_row), .shape(shape), .rot(rot_next),
        .cell_col0(rot_col0), .cell_col1(rot_col1), .cell_col2(rot_col2), .cell_col3(rot_col3),
        .cell_row0(rot_row0), .cell_row1(rot_row1), .cell_row2(rot_row2), .cell_row3(rot_row3)
    );

    collision_probe i_probe (
        .cell_col0(cell_col0), .cell_col1(cell_col1),
        .cell_col2(cell_col2), .cell_col3(cell_col3),
        .cell_row0(cell_row0), .cell_row1(cell_row1),
        .cell_row2(cell_row2), .cell_row3(cell_row3),
        .rot_col0(rot_col0), .rot_col1(rot_col1), .rot_col2(rot_col2), .rot_col3(rot_col3),
        .rot_row0(rot_row0), .rot_row1(rot_row1), .rot_row2(rot_row2), .rot_row3(rot_row3),
        .grid(grid), .at_left(at_left), .at_right(at_right), .at_bottom(at_bottom),
        .rot_blocked(rot_blocked)
    );

    playfield i_field (
        .reset(reset), .clk(clk), .lock(lock), .clear_field(clear_field),
        .cell_col0(cell_col0), .cell_col1(cell_col1),
        .cell_col2(cell_col2), .cell_col3(cell_col3),
        .cell_row0(cell_row0), .cell_row1(cell_row1),
        .cell_row2(cell_row2), .cell_row3(cell_row3),
        .row_sel(row_sel), .grid(grid), .row_bits(row_bits)
    );

endmodule

// File: playfield.sv
`timescale 1ns/1ps

module playfield
    import field_pkg::*;
(
    input  logic       reset,
    input  logic       clk,
    input  logic       lock,
    input  logic       clear_field,
    input  coord_t     cell_col0,
    input  coord_t     cell_col1,
    input  coord_t     cell_col2,
    input  coord_t     cell_col3,
    input  coord_t     cell_row0,
    input  coord_t     cell_row1,
    input  coord_t     cell_row2,
    input  coord_t     cell_row3,
    input  logic [4:0] row_sel,
    output grid_t      grid,
    output row_bits_t  row_bits
);

    grid_t lock_mask;

    // one-hot grid bit for a cell, nothing for a cell off the field
    function automatic grid_t cell_bit(input coord_t c, input coord_t r);
        int idx;
        if (c < 0 || c >= FIELD_COLS || r < 0 || r >= FIELD_ROWS) begin
            return '0;
        end
        idx = int'(r) * FIELD_COLS + int'(c);
        return grid_t'(1) << idx;
    endfunction

    assign lock_mask = cell_bit(cell_col0, cell_row0) | cell_bit(cell_col1, cell_row1) |
                       cell_bit(cell_col2, cell_row2) | cell_bit(cell_col3, cell_row3);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            grid <= '0;
        end else if (clear_field) begin
            grid <= '0;  // clear wins over a lock in the same cycle
        end else if (lock) begin
            grid <= grid | lock_mask;
        end
    end

    assign row_bits = (row_sel < FIELD_ROWS) ?
                      grid[int'(row_sel) * FIELD_COLS +: FIELD_COLS] : '0;

endmodule

// File: collision_probe.sv
`timescale 1ns/1ps

module collision_probe
    import field_pkg::*;
(
    input  coord_t cell_col0,
    input  coord_t cell_col1,
    input  coord_t cell_col2,
    input  coord_t cell_col3,
    input  coord_t cell_row0,
    input  coord_t cell_row1,
    input  coord_t cell_row2,
    input  coord_t cell_row3,
    input  coord_t rot_col0,
    input  coord_t rot_col1,
    input  coord_t rot_col2,
    input  coord_t rot_col3,
    input  coord_t rot_row0,
    input  coord_t rot_row1,
    input  coord_t rot_row2,
    input  coord_t rot_row3,
    input  grid_t  grid,
    output logic   at_left,
    output logic   at_right,
    output logic   at_bottom,
    output logic   rot_blocked
);

    // a cell off the field behaves like a wall
    function automatic logic blocked(input coord_t c, input coord_t r, input grid_t g);
        int idx;
        if (c < 0 || c >= FIELD_COLS || r < 0 || r >= FIELD_ROWS) begin
            return 1'b1;
        end
        idx = int'(r) * FIELD_COLS + int'(c);
        return g[idx];
    endfunction

    localparam coord_t ONE = 6'sd1;

    assign at_left = blocked(cell_col0 - ONE, cell_row0, grid) |
                     blocked(cell_col1 - ONE, cell_row1, grid) |
                     blocked(cell_col2 - ONE, cell_row2, grid) |
                     blocked(cell_col3 - ONE, cell_row3, grid);

    assign at_right = blocked(cell_col0 + ONE, cell_row0, grid) |
                      blocked(cell_col1 + ONE, cell_row1, grid) |
                      blocked(cell_col2 + ONE, cell_row2, grid) |
                      blocked(cell_col3 + ONE, cell_row3, grid);

    assign at_bottom = blocked(cell_col0, cell_row0 + ONE, grid) |  // floor or stack below
                       blocked(cell_col1, cell_row1 + ONE, grid) |
                       blocked(cell_col2, cell_row2 + ONE, grid) |
                       blocked(cell_col3, cell_row3 + ONE, grid);

    assign rot_blocked = blocked(rot_col0, rot_row0, grid) |
                         blocked(rot_col1, rot_row1, grid) |
                         blocked(rot_col2, rot_row2, grid) |
                         blocked(rot_col3, rot_row3, grid);

endmodule

// File: piece_shaper.sv
`timescale 1ns/1ps

module piece_shaper
    import field_pkg::*, piece_pkg::*;
(
    input  coord_t anchor_col,
    input  coord_t anchor_row,
    input  shape_t shape,
    input  rot_t   rot,
    output coord_t cell_col0,
    output coord_t cell_col1,
    output coord_t cell_col2,
    output coord_t cell_col3,
    output coord_t cell_row0,
    output coord_t cell_row1,
    output coord_t cell_row2,
    output coord_t cell_row3
);

    coord_t base_c [4];  // offsets at rotation 0
    coord_t base_r [4];
    coord_t off_c [4];   // offsets after rotation
    coord_t off_r [4];
    rot_t   eff_rot;

    always_comb begin
        base_c = '{0, 1, 0, 1};  // O
        base_r = '{0, 0, 1, 1};
        case (shape)
            SHAPE_I: begin
                base_c = '{-1, 0, 1, 2};
                base_r = '{0, 0, 0, 0};
            end
            SHAPE_S: begin
                base_c = '{0, 1, -1, 0};
                base_r = '{0, 0, 1, 1};
            end
            SHAPE_Z: begin
                base_c = '{-1, 0, 0, 1};
                base_r = '{0, 0, 1, 1};
            end
            SHAPE_L: begin
                base_c = '{-1, 0, 1, 1};
                base_r = '{0, 0, 0, 1};
            end
            SHAPE_J: begin
                base_c = '{-1, 0, 1, -1};
                base_r = '{0, 0, 0, 1};
            end
            SHAPE_T: begin
                base_c = '{-1, 0, 1, 0};
                base_r = '{0, 0, 0, 1};
            end
            default: begin
            end
        endcase
    end

    assign eff_rot = (shape == SHAPE_O) ? rot_t'(0) : rot;  // the square looks the same

    // each quarter turn takes (dc, dr) to (-dr, dc)
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            case (eff_rot)
                2'd0: begin
                    off_c[i] = base_c[i];
                    off_r[i] = base_r[i];
                end
                2'd1: begin
                    off_c[i] = -base_r[i];
                    off_r[i] = base_c[i];
                end
                2'd2: begin
                    off_c[i] = -base_c[i];
                    off_r[i] = -base_r[i];
                end
                default: begin
                    off_c[i] = base_r[i];
                    off_r[i] = -base_c[i];
                end
            endcase
        end
    end

    assign cell_col0 = anchor_col + off_c[0];
    assign cell_col1 = anchor_col + off_c[1];
    assign cell_col2 = anchor_col + off_c[2];
    assign cell_col3 = anchor_col + off_c[3];
    assign cell_row0 = anchor_row + off_r[0];
    assign cell_row1 = anchor_row + off_r[1];
    assign cell_row2 = anchor_row + off_r[2];
    assign cell_row3 = anchor_row + off_r[3];

endmodule

// File: piece_mover.sv
`timescale 1ns/1ps

module piece_mover
    import field_pkg::*, piece_pkg::*;
(
    input  logic   reset,
    input  logic   clk,
    input  logic   move_left,
    input  logic   move_right,
    input  logic   move_down,
    input  logic   rotate,
    input  logic   pause,
    input  coord_t spawn_col,
    input  shape_t next_shape,
    input  logic   at_left,
    input  logic   at_right,
    input  logic   at_bottom,
    input  logic   rot_blocked,
    output coord_t anchor_col,
    output coord_t anchor_row,
    output shape_t shape,
    output rot_t   rot,
    output logic   lock,
    output logic   locked
);

    logic do_left;
    logic do_down;
    logic do_right;
    logic do_rot;

    // one request per cycle, blocked requests fall through to the next
    always_comb begin
        do_left  = 1'b0;
        do_down  = 1'b0;
        do_right = 1'b0;
        do_rot   = 1'b0;
        if (!pause) begin
            if (move_left && !at_left) begin
                do_left = 1'b1;
            end else if (move_down) begin
                do_down = 1'b1;
            end else if (move_right && !at_right) begin
                do_right = 1'b1;
            end else if (rotate && !rot_blocked) begin
                do_rot = 1'b1;
            end
        end
    end

    assign lock = do_down && at_bottom;  // down onto the floor or stack freezes the piece

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            anchor_col <= coord_t'(FIELD_COLS / 2 - 1);
            anchor_row <= SPAWN_ROW;
            shape      <= SHAPE_O;
            rot        <= '0;
            locked     <= 1'b0;
        end else begin
            locked <= lock;
            if (lock) begin
                anchor_col <= spawn_col;  // respawn with the host settings
                anchor_row <= SPAWN_ROW;
                shape      <= next_shape;
                rot        <= '0;
            end else if (do_left) begin
                anchor_col <= anchor_col - coord_t'(1);
            end else if (do_down) begin
                anchor_row <= anchor_row + coord_t'(1);
            end else if (do_right) begin
                anchor_col <= anchor_col + coord_t'(1);
            end else if (do_rot) begin
                rot <= rot + rot_t'(1);  // wraps after the fourth turn
            end
        end
    end

endmodule

// File: piece_regs.sv
`timescale 1ns/1ps

module piece_regs
    import field_pkg::*, piece_pkg::*;
(
    input  logic       reset,
    input  logic       clk,
    input  logic       wr_en,
    input  logic [1:0] wr_addr,
    input  reg_data_t  wr_data,
    output logic       pause,
    output coord_t     spawn_col,
    output shape_t     next_shape,
    output logic       clear_field
);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pause       <= 1'b0;
            spawn_col   <= coord_t'(FIELD_COLS / 2 - 1);  // column 4
            next_shape  <= SHAPE_O;
            clear_field <= 1'b0;
        end else begin
            clear_field <= wr_en && (wr_addr == REG_CLEAR);  // single cycle strobe
            if (wr_en) begin
                case (wr_addr)
                    REG_PAUSE: begin
                        pause <= wr_data[0];
                    end
                    REG_SPAWN_COL: begin
                        if (wr_data < reg_data_t'(FIELD_COLS)) begin
                            spawn_col <= coord_t'(wr_data[5:0]);  // off-field columns dropped
                        end
                    end
                    REG_NEXT_SHAPE: begin
                        if (wr_data <= reg_data_t'(SHAPE_T)) begin
                            next_shape <= shape_t'(wr_data[2:0]);
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// File: piece_pkg.sv
package piece_pkg;

    // the seven tetromino shapes, O first so that reset lands on it
    typedef enum logic [2:0] {
        SHAPE_O,
        SHAPE_I,
        SHAPE_S,
        SHAPE_Z,
        SHAPE_L,
        SHAPE_J,
        SHAPE_T
    } shape_t;

    typedef logic [1:0] rot_t;                       // clockwise quarter turns

    typedef logic [7:0] reg_data_t;                  // host write data

    // host register map
    localparam logic [1:0] REG_PAUSE = 2'd0;         // bit 0 holds the mover
    localparam logic [1:0] REG_SPAWN_COL = 2'd1;     // column for the next spawn
    localparam logic [1:0] REG_NEXT_SHAPE = 2'd2;    // shape for the next spawn
    localparam logic [1:0] REG_CLEAR = 2'd3;         // any write empties the field

endpackage

// File: field_pkg.sv
package field_pkg;

    localparam int FIELD_COLS = 10;                  // columns across the well
    localparam int FIELD_ROWS = 20;                  // rows, row 0 at the top
    localparam int FIELD_CELLS = FIELD_COLS * FIELD_ROWS;

    // signed so that a probe one step past a wall is still representable
    typedef logic signed [5:0] coord_t;

    typedef logic [FIELD_COLS-1:0] row_bits_t;       // one row of occupancy
    typedef logic [FIELD_CELLS-1:0] grid_t;          // index is row * FIELD_COLS + col

    localparam coord_t SPAWN_ROW = 6'sd1;            // one free row above for rotated cells

endpackage
